// File: src/cfg_loader_pkg.sv
// -----------------------------------------------
// Widths, command codes and record types shared by
// the configuration loader stages, by scoped names
// -----------------------------------------------
package cfg_loader_pkg;

    // -----------------------------------------------
    // Widths
    // -----------------------------------------------
    localparam int DATA_W    = 32;
    localparam int ADDR_W    = 32;
    localparam int SHIFT_W   = 5;
    localparam int CMD_W     = 2;
    localparam int ID_W      = 4;
    localparam int CFG_WORDS = 8;

    // Memory command carried by each response word
    typedef enum logic [CMD_W-1:0] {
        CMD_INVALID     = 2'd0,
        CMD_MEM_READ    = 2'd1,
        CMD_MEM_WRITE   = 2'd2,
        CMD_MEM_PROGRAM = 2'd3
    } mem_cmd_e;

    // One memory response word, 72 bits
    typedef struct packed {
        logic               valid;
        mem_cmd_e           cmd;
        logic [ADDR_W-1:0]  offset;
        logic [SHIFT_W-1:0] shift_amount;
        logic [DATA_W-1:0]  data;
    } mem_response_t;

    // -----------------------------------------------
    // Configuration word views
    // -----------------------------------------------
    // Flag bits sit at the bottom, increment in bit 0
    typedef struct packed {
        logic [DATA_W-6:0] reserved;
        logic              mode_counter;
        logic              mode_buffer;
        logic              mode_sequence;
        logic              decrement;
        logic              increment;
    } cfg_mode_view_t;

    typedef struct packed {
        logic              direction;
        logic [DATA_W-2:0] granularity;
    } cfg_shift_view_t;

    typedef union packed {
        logic [DATA_W-1:0] raw;
        cfg_mode_view_t    mode_view;
        cfg_shift_view_t   shift_view;
    } cfg_word_u;

    // Filtered word handed from filter to loader, 34 bits
    typedef struct packed {
        logic      valid;
        logic      first;
        cfg_word_u data;
    } cfg_word_t;

    // -----------------------------------------------
    // Finished record, 207 bits
    // -----------------------------------------------
    typedef struct packed {
        logic              increment;
        logic              decrement;
        logic              mode_sequence;
        logic              mode_buffer;
        logic              mode_counter;
        logic [DATA_W-1:0] index_start;
        logic [DATA_W-1:0] index_end;
        logic [DATA_W-1:0] stride;
        logic [DATA_W-2:0] granularity;
        logic              direction;
        mem_cmd_e          cmd;
        logic [ID_W-1:0]   id_module;
        logic [ID_W-1:0]   id_engine;
        logic [DATA_W-1:0] array_size;
        logic [DATA_W-1:0] const_value;
    } cfg_record_t;

endpackage

// File: src/cfg_word_filter.sv
// -----------------------------------------------
// Decode stage: registers each response and keeps
// only program words inside this engine's window
// -----------------------------------------------
`timescale 1ns/1ps

module cfg_word_filter #(
    parameter int unsigned SEQ_MIN = 0
) (
    input  logic                          ap_clk,
    input  logic                          reset,
    input  cfg_loader_pkg::mem_response_t resp_in,
    input  logic                          loading,
    output cfg_loader_pkg::cfg_word_t     word
);

    // Upper bound of the window, exclusive
    localparam logic [cfg_loader_pkg::ADDR_W-1:0] SEQ_LO =
        cfg_loader_pkg::ADDR_W'(SEQ_MIN);
    localparam logic [cfg_loader_pkg::ADDR_W-1:0] SEQ_HI =
        cfg_loader_pkg::ADDR_W'(SEQ_MIN + cfg_loader_pkg::CFG_WORDS);

    logic                                valid_q;
    cfg_loader_pkg::mem_response_t       resp_q;
    logic [cfg_loader_pkg::ADDR_W-1:0]   scaled_offset;
    logic                                in_window;
    logic                                keep;

    // -----------------------------------------------
    // Input register
    // -----------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= resp_in.valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        resp_q <= resp_in;
    end

    // -----------------------------------------------
    // Window check on the scaled offset
    // -----------------------------------------------
    assign scaled_offset = resp_q.offset >> resp_q.shift_amount;
    assign in_window     = (scaled_offset >= SEQ_LO) && (scaled_offset < SEQ_HI);
    assign keep          = valid_q && (resp_q.cmd == cfg_loader_pkg::CMD_MEM_PROGRAM)
                           && in_window;

    // Only a word at the window base may open a new record
    assign word.valid = keep;
    assign word.first = keep && (scaled_offset == SEQ_LO) && !loading;
    assign word.data  = resp_q.data;

endmodule

// File: src/cfg_field_loader.sv
// -----------------------------------------------
// Execute stage: follows the one-hot word position
// and decodes each kept word into the record
// -----------------------------------------------
`timescale 1ns/1ps

module cfg_field_loader (
    input  logic                        ap_clk,
    input  logic                        reset,
    input  cfg_loader_pkg::cfg_word_t   word,
    output logic                        loading,
    output cfg_loader_pkg::cfg_record_t rec,
    output logic                        rec_valid
);

    localparam int N = cfg_loader_pkg::CFG_WORDS;

    // Position of the last stored word, zero when idle
    logic [N-1:0] pos;
    // Position of the word on the input this cycle
    logic [N-1:0] word_pos;
    logic         last_stored;

    assign loading = |pos;

    // -----------------------------------------------
    // Position sequencing
    // -----------------------------------------------
    always_comb begin
        word_pos = '0;
        if (word.valid) begin
            if (word.first) begin
                word_pos = N'(1);
            end else if (loading) begin
                word_pos = pos << 1;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (reset) begin
            pos         <= '0;
            last_stored <= 1'b0;
            rec_valid   <= 1'b0;
        end else begin
            rec_valid   <= last_stored;
            last_stored <= word_pos[N-1];
            if (|word_pos) begin
                // Clear right after the final word so the next run can open
                pos <= word_pos[N-1] ? '0 : word_pos;
            end
        end
    end

    // -----------------------------------------------
    // Field decode per position
    // -----------------------------------------------
    // Fields not written keep the value of the last record
    always_ff @(posedge ap_clk) begin
        case (1'b1)
            word_pos[0]: begin
                rec.increment     <= word.data.mode_view.increment;
                rec.decrement     <= word.data.mode_view.decrement;
                rec.mode_sequence <= word.data.mode_view.mode_sequence;
                rec.mode_buffer   <= word.data.mode_view.mode_buffer;
                rec.mode_counter  <= word.data.mode_view.mode_counter;
            end
            word_pos[1]: begin
                rec.index_start <= word.data.raw;
            end
            word_pos[2]: begin
                rec.index_end <= word.data.raw;
            end
            word_pos[3]: begin
                rec.stride <= word.data.raw;
            end
            word_pos[4]: begin
                rec.granularity <= word.data.shift_view.granularity;
                rec.direction   <= word.data.shift_view.direction;
            end
            word_pos[5]: begin
                // Target select: cmd, module id, engine id from the bottom up
                rec.cmd       <= cfg_loader_pkg::mem_cmd_e'(word.data.raw[1:0]);
                rec.id_module <= word.data.raw[5:2];
                rec.id_engine <= word.data.raw[9:6];
            end
            word_pos[6]: begin
                rec.array_size <= word.data.raw;
            end
            word_pos[7]: begin
                rec.const_value <= word.data.raw;
            end
            default: begin
                rec <= rec;
            end
        endcase
    end

endmodule

// File: src/cfg_record_queue.sv
// -----------------------------------------------
// Result stage: register FIFO of finished records,
// released one per cycle while credits are held
// -----------------------------------------------
`timescale 1ns/1ps

module cfg_record_queue #(
    parameter int QUEUE_DEPTH = 4,
    parameter int CREDIT_INIT = 2
) (
    input  logic                                 ap_clk,
    input  logic                                 reset,
    input  cfg_loader_pkg::cfg_record_t          rec,
    input  logic                                 rec_valid,
    input  logic                                 credit_return,
    output cfg_loader_pkg::cfg_record_t          cfg_out,
    output logic                                 cfg_out_valid,
    output logic                                 cfg_ready,
    output logic                                 cfg_full,
    output logic [$clog2(QUEUE_DEPTH+1)-1:0]     queue_count
);

    localparam int PTR_W  = $clog2(QUEUE_DEPTH);
    localparam int CNT_W  = $clog2(QUEUE_DEPTH + 1);
    localparam int CRED_W = $clog2(CREDIT_INIT + 1);

    cfg_loader_pkg::cfg_record_t mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic [CRED_W-1:0] credits;
    logic              push;
    logic              pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        next_ptr = (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // A record arriving on a full queue is dropped
    assign cfg_full    = (count == CNT_W'(QUEUE_DEPTH));
    assign push        = rec_valid && !cfg_full;
    assign pop         = (count != '0) && (credits != '0);
    assign queue_count = count;

    // -----------------------------------------------
    // Pointers, fill level and credits
    // -----------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (reset) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credits       <= CRED_W'(CREDIT_INIT);
            cfg_out_valid <= 1'b0;
            cfg_ready     <= 1'b0;
        end else begin
            cfg_ready     <= 1'b1;
            cfg_out_valid <= pop;
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({credit_return, pop})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // Storage and output data
    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= rec;
        end
        if (pop) begin
            cfg_out <= mem[rd_ptr];
        end
    end

endmodule

// File: src/engine_cfg_loader.sv
// -----------------------------------------------
// Engine configuration loader top level: filter,
// field loader and credit-gated record queue
// -----------------------------------------------
`timescale 1ns/1ps

module engine_cfg_loader #(
    parameter int ENGINE_SLOT = 0,
    parameter int QUEUE_DEPTH = 4,
    parameter int CREDIT_INIT = 2
) (
    input  logic                             ap_clk,
    input  logic                             reset,
    input  cfg_loader_pkg::mem_response_t    resp_in,
    input  logic                             credit_return,
    output cfg_loader_pkg::cfg_record_t      cfg_out,
    output logic                             cfg_out_valid,
    output logic                             cfg_ready,
    output logic                             cfg_full,
    output logic [$clog2(QUEUE_DEPTH+1)-1:0] queue_count
);

    // Each engine owns one window of CFG_WORDS offsets
    localparam int unsigned SEQ_MIN = ENGINE_SLOT * cfg_loader_pkg::CFG_WORDS;

    cfg_loader_pkg::cfg_word_t   word;
    cfg_loader_pkg::cfg_record_t rec;
    logic                        loading;
    logic                        rec_valid;

    // -----------------------------------------------
    // Stages
    // -----------------------------------------------
    cfg_word_filter #(
        .SEQ_MIN(SEQ_MIN)
    ) u_filter (
        .ap_clk (ap_clk),
        .reset  (reset),
        .resp_in(resp_in),
        .loading(loading),
        .word   (word)
    );

    cfg_field_loader u_loader (
        .ap_clk   (ap_clk),
        .reset    (reset),
        .word     (word),
        .loading  (loading),
        .rec      (rec),
        .rec_valid(rec_valid)
    );

    cfg_record_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .CREDIT_INIT(CREDIT_INIT)
    ) u_queue (
        .ap_clk       (ap_clk),
        .reset        (reset),
        .rec          (rec),
        .rec_valid    (rec_valid),
        .credit_return(credit_return),
        .cfg_out      (cfg_out),
        .cfg_out_valid(cfg_out_valid),
        .cfg_ready    (cfg_ready),
        .cfg_full     (cfg_full),
        .queue_count  (queue_count)
    );

endmodule

// File: test/cfg_checker.sv
// --------------------------------------------------
// Record checker: compares each presented record with
// the next expected one, oldest first
// --------------------------------------------------
`timescale 1ns/1ps

module cfg_checker (
    input  logic                        ap_clk,
    input  logic                        reset,
    input  cfg_loader_pkg::cfg_record_t cfg_out,
    input  logic                        cfg_out_valid,
    output int                          error_count,
    output int                          record_count
);

    // Filled by the testbench, oldest record first
    cfg_loader_pkg::cfg_record_t expected_q [$];
    cfg_loader_pkg::cfg_record_t exp_rec;

    // Outputs are stable in the middle of the cycle
    always @(negedge ap_clk) begin
        if (reset) begin
            error_count  = 0;
            record_count = 0;
        end else begin
            if (cfg_out_valid === 1'b1) begin
                if (expected_q.size() == 0) begin
                    $display("A record was presented on cfg_out while none was expected");
                    error_count++;
                end else begin
                    exp_rec = expected_q.pop_front();
                    record_count++;
                    if (cfg_out !== exp_rec) begin
                        $display("** Error cfg_out: got 0x%h, expected 0x%h", cfg_out, exp_rec);
                        error_count++;
                    end
                end
            end
        end
    end

endmodule

// File: test/tb_engine_cfg_loader.sv
// --------------------------------------------------
// Testbench for the engine configuration loader;
// applies the stimulus table and checks the credits
// --------------------------------------------------
`timescale 1ns/1ps

module tb_engine_cfg_loader;

    localparam int SEQ_MIN      = 8;
    localparam int WIN_END      = SEQ_MIN + cfg_loader_pkg::CFG_WORDS;
    localparam int ROWS         = 6;
    localparam int QUEUE_DEPTH  = 4;
    localparam int CREDIT_INIT  = 2;
    localparam int MAX_GAP      = 3;
    localparam int CREDIT_DELAY = 5;
    localparam int QUIET        = 8;
    localparam int unsigned SEED = 32'h472c8f8b;
    // Each word may be followed by a foreign word and an idle gap
    localparam int WATCHDOG_NS =
        (ROWS * 8 * (MAX_GAP + 2) + QUEUE_DEPTH * (CREDIT_DELAY + QUIET + 4) + 64) * 10 * 2;

    logic                             ap_clk;
    logic                             reset;
    cfg_loader_pkg::mem_response_t    resp_in;
    logic                             credit_return;
    cfg_loader_pkg::cfg_record_t      cfg_out;
    logic                             cfg_out_valid;
    logic                             cfg_ready;
    logic                             cfg_full;
    logic [$clog2(QUEUE_DEPTH+1)-1:0] queue_count;
    int                               checker_errors;
    int                               record_count;
    int                               tb_errors;
    int unsigned                      seed_value;

    // --------------------------------------------------
    // Stimulus table
    // --------------------------------------------------
    // Columns: data words for positions 0 to 7; shift and foreign flag per row below
    logic [31:0] row_words [ROWS][8] = '{
        '{32'h0000_0015, 32'h0000_1000, 32'h0000_1fff, 32'h0000_0004,
          32'h8000_0040, 32'h0000_02a7, 32'h0000_0100, 32'hdead_beef},
        '{32'h0000_000a, 32'h0002_0000, 32'h0002_ffff, 32'h0000_0010,
          32'h7fff_ffff, 32'h0000_0156, 32'h0000_0400, 32'h1234_5678},
        '{32'h0000_001f, 32'h0000_0000, 32'hffff_ffff, 32'h0000_0001,
          32'h0000_0003, 32'h0000_03fd, 32'h0000_0020, 32'ha5a5_5a5a},
        '{32'h0000_0006, 32'h1000_0000, 32'h1000_0fff, 32'h0000_0008,
          32'hc000_0001, 32'h0000_0081, 32'h0000_0800, 32'h0bad_f00d},
        '{32'hffff_ffe9, 32'h0000_4000, 32'h0000_4fff, 32'h0000_0002,
          32'h8000_0000, 32'hffff_fc1e, 32'h0000_1000, 32'hcafe_f00d},
        '{32'h0000_0011, 32'h0030_0000, 32'h003f_ffff, 32'h0000_0020,
          32'h4000_0400, 32'h0000_0342, 32'h0000_0008, 32'h600d_cafe}
    };
    logic [4:0] row_shift   [ROWS] = '{5'd0, 5'd0, 5'd2, 5'd3, 5'd0, 5'd1};
    logic       row_foreign [ROWS] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1};
    cfg_loader_pkg::cfg_record_t exp_table [ROWS];

    engine_cfg_loader #(
        .ENGINE_SLOT(1),
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .CREDIT_INIT(CREDIT_INIT)
    ) DUT (
        .ap_clk       (ap_clk),
        .reset        (reset),
        .resp_in      (resp_in),
        .credit_return(credit_return),
        .cfg_out      (cfg_out),
        .cfg_out_valid(cfg_out_valid),
        .cfg_ready    (cfg_ready),
        .cfg_full     (cfg_full),
        .queue_count  (queue_count)
    );

    cfg_checker u_checker (
        .ap_clk       (ap_clk),
        .reset        (reset),
        .cfg_out      (cfg_out),
        .cfg_out_valid(cfg_out_valid),
        .error_count  (checker_errors),
        .record_count (record_count)
    );

    initial begin
        ap_clk = 1'b0;
        forever #5 ap_clk = ~ap_clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Regression failed");
        $finish;
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
            tb_errors++;
        end
    endtask

    // Word 0 flags from bit 0 up, word 4 direction over granularity, word 5 target select
    function automatic cfg_loader_pkg::cfg_record_t expected_record(input int r);
        logic [31:0] w [8];
        w = row_words[r];
        return {w[0][0], w[0][1], w[0][2], w[0][3], w[0][4], w[1], w[2], w[3],
                w[4][30:0], w[4][31], w[5][1:0], w[5][5:2], w[5][9:6], w[6], w[7]};
    endfunction

    task automatic drive_word(input cfg_loader_pkg::mem_cmd_e cmd, input logic [31:0] offset,
                              input logic [4:0] shift, input logic [31:0] data);
        cfg_loader_pkg::mem_response_t resp;
        resp.valid        = 1'b1;
        resp.cmd          = cmd;
        resp.offset       = offset;
        resp.shift_amount = shift;
        resp.data         = data;
        @(posedge ap_clk);
        resp_in <= resp;
    endtask

    task automatic drive_idle();
        @(posedge ap_clk);
        resp_in <= '0;
    endtask

    // Words the filter must drop: wrong command or scaled offset outside the window
    task automatic send_foreign(input int kind, input logic [4:0] sh);
        case (kind % 4)
            0: drive_word(cfg_loader_pkg::CMD_MEM_READ, 32'(SEQ_MIN) << sh, sh, $urandom);
            1: drive_word(cfg_loader_pkg::CMD_MEM_PROGRAM, 32'(WIN_END) << sh, sh, $urandom);
            2: drive_word(cfg_loader_pkg::CMD_MEM_PROGRAM, 32'(SEQ_MIN - 1) << sh, sh, $urandom);
            default: drive_word(cfg_loader_pkg::CMD_MEM_WRITE, 32'(SEQ_MIN + 3) << sh, sh,
                                $urandom);
        endcase
    endtask

    task automatic send_row(input int r);
        logic [4:0] sh;
        int         gap;
        sh = row_shift[r];
        u_checker.expected_q.push_back(exp_table[r]);
        for (int p = 0; p < 8; p++) begin
            drive_word(cfg_loader_pkg::CMD_MEM_PROGRAM, 32'(SEQ_MIN + p) << sh, sh,
                       row_words[r][p]);
            if (row_foreign[r] && p < 7) begin
                send_foreign(p, sh);
            end
            gap = int'($urandom % (MAX_GAP + 1));
            repeat (gap) drive_idle();
        end
        drive_idle();
    endtask

    task automatic give_credit();
        repeat (CREDIT_DELAY) @(posedge ap_clk);
        credit_return <= 1'b1;
        @(posedge ap_clk);
        credit_return <= 1'b0;
    endtask

    task automatic wait_records(input int n);
        while (record_count < n) begin
            @(negedge ap_clk);
        end
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        seed_value    = $urandom(SEED);
        tb_errors     = 0;
        reset         = 1'b1;
        credit_return = 1'b0;
        resp_in       = '0;
        for (int r = 0; r < ROWS; r++) begin
            exp_table[r] = expected_record(r);
        end
        repeat (16) @(posedge ap_clk);
        reset <= 1'b0;
        @(posedge ap_clk);
        @(negedge ap_clk);
        check_value("cfg_ready", 32'(cfg_ready), 32'd1);
        check_value("cfg_out_valid", 32'(cfg_out_valid), 32'd0);
        check_value("cfg_full", 32'(cfg_full), 32'd0);
        check_value("queue_count", 32'(queue_count), 32'd0);

        // Records pass straight through while the initial credits last
        for (int r = 0; r < CREDIT_INIT; r++) begin
            send_row(r);
        end
        wait_records(CREDIT_INIT);

        // No credits left, so the queue fills up
        for (int r = CREDIT_INIT; r < ROWS; r++) begin
            send_row(r);
        end
        while (32'(queue_count) != QUEUE_DEPTH) begin
            @(negedge ap_clk);
        end
        repeat (QUIET) @(negedge ap_clk);
        check_value("record_count", 32'(record_count), 32'(CREDIT_INIT));
        check_value("cfg_full", 32'(cfg_full), 32'd1);

        // Each returned credit releases exactly one record
        for (int k = 1; k <= QUEUE_DEPTH; k++) begin
            give_credit();
            wait_records(CREDIT_INIT + k);
            repeat (QUIET) @(negedge ap_clk);
            check_value("record_count", 32'(record_count), 32'(CREDIT_INIT + k));
            check_value("queue_count", 32'(queue_count), 32'(QUEUE_DEPTH - k));
            check_value("cfg_full", 32'(cfg_full), 32'd0);
        end
        check_value("queue_count", 32'(queue_count), 32'd0);

        $display("Errors: testbench %0d, checker %0d", tb_errors, checker_errors);
        if (tb_errors == 0 && checker_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: engine_cfg_loader.f
src/cfg_loader_pkg.sv
src/cfg_word_filter.sv
src/cfg_field_loader.sv
src/cfg_record_queue.sv
src/engine_cfg_loader.sv
test/cfg_checker.sv
test/tb_engine_cfg_loader.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the configuration loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
TOP=tb_engine_cfg_loader

verilator --binary --timing -f engine_cfg_loader.f --top-module "$TOP" -Mdir "$OBJ"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
